// File: src.f
+incdir+logic
logic/wr_path_pkg.sv
logic/queue_if.sv
logic/sync_fifo.sv
logic/write_sequencer.sv
logic/dnn_write_path.sv
verif/dnn_write_path_sva.sv
verif/dnn_write_path_tb.sv

// File: verif/dnn_write_path_tb.sv
// self-checking testbench that drives dnn_write_path from PU buffer models and scores each beat
`include "wr_path_consts.svh"

module dnn_write_path_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DW          = `WRP_DATA_W;
  localparam int MAX_BEATS   = 4 + 8 + 20 * 12 + 8 * 12 + 6 * 12;  // worst case over all tests
  localparam int WATCHDOG_CY = MAX_BEATS * 40 + 500;

  logic                             clk;
  logic                             rst;
  logic                             wr_req;
  logic [`WRP_ADDR_W-1:0]           wr_addr;
  logic [`WRP_SIZE_W-1:0]           wr_size;
  wr_path_pkg::pu_id_t              wr_pu_id;
  logic                             wr_ready;
  logic                             wr_done;
  logic [`WRP_NUM_PU-1:0]           outbuf_empty;
  logic [`WRP_NUM_PU*DW-1:0]        outbuf_data;
  logic [`WRP_NUM_PU-1:0]           outbuf_pop;
  logic                             req_valid;
  logic                             req_grant;
  logic [`WRP_MEM_ADDR_W-1:0]       req_addr;
  logic [DW-1:0]                    req_data;

  logic [DW-1:0]      pu_buf    [`WRP_NUM_PU][$];  // words the buffer shows to the DUT
  logic [DW-1:0]      pending   [`WRP_NUM_PU][$];  // supplied but not yet refilled
  logic [DW-1:0]      ref_words [`WRP_NUM_PU][$];  // supply order, consumed by the reference
  wr_path_pkg::beat_t sb        [$];               // expected beats in issue order

  string test_name;
  int    errors;
  int    checks;
  int    grant_pct;   // chance of req_grant per cycle
  int    starve_pct;  // chance a refill is held back
  int    done_count;  // wr_done pulses seen in this test
  int    req_count;   // requests issued in this test

  dnn_write_path i_dnn_write_path (
    .clk          (clk),
    .rst          (rst),
    .wr_req       (wr_req),
    .wr_addr      (wr_addr),
    .wr_size      (wr_size),
    .wr_pu_id     (wr_pu_id),
    .wr_ready     (wr_ready),
    .wr_done      (wr_done),
    .outbuf_empty (outbuf_empty),
    .outbuf_data  (outbuf_data),
    .outbuf_pop   (outbuf_pop),
    .req_valid    (req_valid),
    .req_grant    (req_grant),
    .req_addr     (req_addr),
    .req_data     (req_data)
  );

  always #2 clk = ~clk;  // 4 ns period

  // address of beat idx steps by the beat size from the start
  function automatic wr_path_pkg::beat_t expected_beat(input logic [`WRP_ADDR_W-1:0] start,
                                                       input int unsigned idx,
                                                       input logic [DW-1:0] word);
    wr_path_pkg::beat_t b;
    logic [`WRP_ADDR_W-1:0] a;
    a      = start + `WRP_ADDR_W'(idx * `WRP_BEAT_BYTES);  // wraps in 32 bits
    b.addr = `WRP_MEM_ADDR_W'(a);
    b.data = word;
    return b;
  endfunction

  task automatic check(input string name, input logic [127:0] expected,
                       input logic [127:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // hand words to a PU buffer model, in supply order
  task automatic supply_words(input int pu, input int n);
    logic [DW-1:0] w;
    for (int i = 0; i < n; i++) begin
      w = {$urandom(), $urandom()};
      pending[pu].push_back(w);
      ref_words[pu].push_back(w);
    end
  endtask

  // waits at falling edges for ready and strobes one request
  task automatic send_request(input logic [`WRP_ADDR_W-1:0] addr, input int size, input int pu);
    while (!wr_ready) @(negedge clk);
    supply_words(pu, size);
    for (int i = 0; i < size; i++) begin
      sb.push_back(expected_beat(addr, i, ref_words[pu].pop_front()));
    end
    wr_req   = 1'b1;
    wr_addr  = addr;
    wr_size  = `WRP_SIZE_W'(size);
    wr_pu_id = wr_path_pkg::pu_id_t'(pu);
    @(negedge clk);
    wr_req = 1'b0;  // strobe lasts one cycle
    req_count++;
  endtask

  task automatic send_random_request();
    send_request($urandom() & 32'hffff_fff8, $urandom_range(12, 1),
                 $urandom_range(`WRP_NUM_PU - 1, 0));
  endtask

  // drain and confirm beats and done pulses are all accounted for
  task automatic finish_test();
    @(negedge clk);
    while (!wr_ready) @(negedge clk);
    if (sb.size() != 0) begin
      errors++;
      $display("%s: %0d expected beats never reached memory", test_name, sb.size());
    end
    repeat (3) begin
      @(negedge clk);
      check({test_name, " wr_ready after drain"}, 1, wr_ready);  // stays idle
    end
    if (done_count != req_count) begin
      errors++;
      $display("%s: saw %0d wr_done pulses for %0d requests", test_name, done_count,
               req_count);
    end
    done_count = 0;
    req_count  = 0;
  endtask

  // buffer models and memory grant driven on the falling edge
  always @(negedge clk) begin
    for (int p = 0; p < `WRP_NUM_PU; p++) begin
      if (pending[p].size() != 0 && $urandom_range(99) >= starve_pct) begin
        pu_buf[p].push_back(pending[p].pop_front());  // one refill per cycle
      end
      outbuf_empty[p]          = (pu_buf[p].size() == 0);
      outbuf_data[p*DW +: DW]  = (pu_buf[p].size() != 0) ? pu_buf[p][0] : '0;
    end
    req_grant = ($urandom_range(99) < grant_pct);
  end

  // a pop consumes the head word shown in that cycle
  always @(posedge clk) begin
    if (!rst) begin
      for (int p = 0; p < `WRP_NUM_PU; p++) begin
        if (outbuf_pop[p]) begin
          if (pu_buf[p].size() == 0) begin
            errors++;
            $display("%s: PU %0d popped with no word in its buffer", test_name, p);
          end else begin
            void'(pu_buf[p].pop_front());
          end
        end
      end
    end
  end

  // compare every transferred beat with the scoreboard
  always @(posedge clk) begin
    wr_path_pkg::beat_t exp_beat;
    if (!rst) begin
      if (req_valid && req_grant) begin
        if (sb.size() == 0) begin
          errors++;
          $display("%s: unexpected beat to address %0h", test_name, req_addr);
        end else begin
          exp_beat = sb.pop_front();
          check({test_name, " req_addr"}, exp_beat.addr, req_addr);
          check({test_name, " req_data"}, exp_beat.data, req_data);
        end
      end
      if (wr_done) begin
        done_count++;
      end
      if (wr_ready && !wr_req && sb.size() != 0) begin  // idle with beats outstanding
        errors++;
        $display("%s: wr_ready high while %0d beats are outstanding", test_name, sb.size());
      end
    end
  end

  initial begin
    void'($urandom(32'h425e1c72));
    clk          = 1'b0;
    rst          = 1'b1;
    wr_req       = 1'b0;
    wr_addr      = '0;
    wr_size      = '0;
    wr_pu_id     = '0;
    outbuf_empty = '1;
    outbuf_data  = '0;
    req_grant    = 1'b0;
    errors       = 0;
    checks       = 0;
    grant_pct    = 100;
    starve_pct   = 0;
    done_count   = 0;
    req_count    = 0;
    test_name    = "reset";
    supply_words(1, 1);  // pu 1 shows a word through reset
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check("reset wr_ready", 1, wr_ready);
    check("reset req_valid", 0, req_valid);
    check("reset wr_done", 0, wr_done);
    check("reset outbuf_pop", 0, outbuf_pop);

    test_name = "single_request";
    send_request(32'h0000_1000, 4, 0);
    finish_test();

    test_name = "pu_select";
    supply_words(0, 3);  // pu 0 words must stay put
    send_request(32'h0000_2000, 5, 1);
    send_request(32'h0000_3008, 3, 1);
    finish_test();
    check("pu_select pu0 words left", 3, pu_buf[0].size() + pending[0].size());

    test_name = "request_sequence";
    repeat (20) send_random_request();
    finish_test();

    test_name = "back_pressure";
    grant_pct = 30;
    repeat (8) send_random_request();
    finish_test();
    grant_pct = 100;

    test_name = "starvation";
    starve_pct = 75;
    repeat (6) send_random_request();
    finish_test();
    starve_pct = 0;

    if (sb.size() != 0) begin
      errors++;
      $display("%0d leftover beats were never transferred", sb.size());
    end
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog sized from the worst-case beat count
  initial begin
    repeat (WATCHDOG_CY) @(posedge clk);
    errors++;
    $display("timeout: run did not complete within %0d cycles in %s", WATCHDOG_CY, test_name);
    $display("errors: %0d, checks: %0d", errors, checks);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: verif/dnn_write_path_sva.sv
// protocol assertions for the write path ports, attached to every dnn_write_path by bind
`include "wr_path_consts.svh"

module dnn_write_path_sva (
  input logic                   clk,
  input logic                   rst,
  input logic                   wr_req,
  input logic [`WRP_SIZE_W-1:0] wr_size,
  input logic                   wr_ready,
  input logic                   wr_done,
  input logic [`WRP_NUM_PU-1:0] outbuf_empty,
  input logic [`WRP_NUM_PU-1:0] outbuf_pop,
  input logic                   req_valid,
  input logic                   req_grant
);

  timeunit 1ns;
  timeprecision 100ps;

  // a buffer is only popped while it holds a word
  a_pop_not_empty: assert property (@(posedge clk) disable iff (rst)
    (outbuf_pop & outbuf_empty) == '0)
    else $error("output buffer popped while empty");

  // only the selected PU is drained
  a_pop_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(outbuf_pop))
    else $error("more than one output buffer popped in a cycle");

  a_valid_hold: assert property (@(posedge clk) disable iff (rst)
    req_valid && !req_grant |=> req_valid)  // offered beat waits for grant
    else $error("req_valid dropped before grant");

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) wr_done |=> !wr_done)
    else $error("wr_done high for two cycles");

  // accepted request leaves the path busy
  a_busy_after_req: assert property (@(posedge clk) disable iff (rst) wr_req |=> !wr_ready)
    else $error("wr_ready still high after a request");

  // controller side rule
  a_req_legal: assert property (@(posedge clk) disable iff (rst)
    wr_req |-> wr_ready && (wr_size != '0))
    else $error("request strobe without ready or with zero length");

endmodule

bind dnn_write_path dnn_write_path_sva i_dnn_write_path_sva (
  .clk          (clk),
  .rst          (rst),
  .wr_req       (wr_req),
  .wr_size      (wr_size),
  .wr_ready     (wr_ready),
  .wr_done      (wr_done),
  .outbuf_empty (outbuf_empty),
  .outbuf_pop   (outbuf_pop),
  .req_valid    (req_valid),
  .req_grant    (req_grant)
);

// File: logic/dnn_write_path.sv
// write path top: queues controller write requests and drives beat writes to memory
`include "wr_path_consts.svh"

module dnn_write_path (
  input  logic                                clk,
  input  logic                                rst,

  // controller side
  input  logic                                wr_req,      // one-cycle strobe while wr_ready
  input  logic [`WRP_ADDR_W-1:0]              wr_addr,     // start byte address
  input  logic [`WRP_SIZE_W-1:0]              wr_size,     // length in beats
  input  wr_path_pkg::pu_id_t                 wr_pu_id,
  output logic                                wr_ready,    // nothing queued or in flight
  output logic                                wr_done,     // last beat of a request issued

  // PU output buffers
  input  logic [`WRP_NUM_PU-1:0]              outbuf_empty,
  input  logic [`WRP_NUM_PU*`WRP_DATA_W-1:0]  outbuf_data, // pu 0 in low word
  output logic [`WRP_NUM_PU-1:0]              outbuf_pop,

  // memory system
  output logic                                req_valid,
  input  logic                                req_grant,
  output logic [`WRP_MEM_ADDR_W-1:0]          req_addr,
  output logic [`WRP_DATA_W-1:0]              req_data
);

  queue_if #(.payload_t(wr_path_pkg::macro_req_t)) macro_q ();
  queue_if #(.payload_t(wr_path_pkg::beat_t))      beat_q ();

  logic                                    seq_busy;   // sequencer holds a request
  logic [`WRP_NUM_PU-1:0][`WRP_DATA_W-1:0] pu_words;   // buffer data split per PU

  assign pu_words = outbuf_data;

  // request strobe into the macro queue, dropped if full
  assign macro_q.push           = wr_req && !macro_q.full;
  assign macro_q.push_data.addr  = wr_addr;
  assign macro_q.push_data.size  = wr_size;
  assign macro_q.push_data.pu_id = wr_pu_id;

  sync_fifo #(
    .payload_t (wr_path_pkg::macro_req_t),
    .LOG_DEPTH (`WRP_MACRO_Q_LOG_DEPTH)
  ) macro_fifo (
    .clk (clk),
    .rst (rst),
    .q   (macro_q)
  );

  write_sequencer i_write_sequencer (
    .clk          (clk),
    .rst          (rst),
    .macro_q      (macro_q),
    .beat_q       (beat_q),
    .outbuf_empty (outbuf_empty),
    .outbuf_data  (pu_words),
    .outbuf_pop   (outbuf_pop),
    .busy         (seq_busy),
    .wr_done      (wr_done)
  );

  sync_fifo #(
    .payload_t (wr_path_pkg::beat_t),
    .LOG_DEPTH (`WRP_BEAT_Q_LOG_DEPTH)
  ) beat_fifo (
    .clk (clk),
    .rst (rst),
    .q   (beat_q)
  );

  // memory side, head beat offered until granted
  assign req_valid  = !beat_q.empty;
  assign req_addr   = beat_q.pop_data.addr;
  assign req_data   = beat_q.pop_data.data;
  assign beat_q.pop = req_valid && req_grant;  // transfer

  // idle only when both queues are drained and no request is active
  assign wr_ready = macro_q.empty && !seq_busy && beat_q.empty;

endmodule

// File: logic/write_sequencer.sv
// splits queued macro write requests into single-beat memory writes fed from PU buffers
`include "wr_path_consts.svh"

module write_sequencer (
  input  logic                                    clk,
  input  logic                                    rst,
  queue_if.consumer                               macro_q,      // macro_req_t entries
  queue_if.producer                               beat_q,       // beat_t entries
  input  logic [`WRP_NUM_PU-1:0]                  outbuf_empty,
  input  logic [`WRP_NUM_PU-1:0][`WRP_DATA_W-1:0] outbuf_data,  // pu 0 in low word
  output logic [`WRP_NUM_PU-1:0]                  outbuf_pop,
  output logic                                    busy,
  output logic                                    wr_done
);

  // current macro request being sequenced
  logic                   active;      // a request is loaded
  logic [`WRP_ADDR_W-1:0] cur_addr;    // byte address of next beat
  logic [`WRP_SIZE_W-1:0] beats_left;  // beats still to issue
  wr_path_pkg::pu_id_t    cur_pu;      // buffer the data comes from

  wr_path_pkg::macro_req_t next_req;   // head of the macro queue
  wr_path_pkg::beat_t      beat;       // beat formed this cycle

  logic accept;     // take a new macro request
  logic issue;      // push one beat this cycle
  logic last_beat;  // beat being issued is the final one

  assign next_req = macro_q.pop_data;

  // activation: only when idle and something is queued
  assign accept      = !active && !macro_q.empty;
  assign macro_q.pop = accept;

  // a beat goes out when the chosen buffer has data and there is room downstream
  assign issue     = active && !outbuf_empty[cur_pu] && !beat_q.full;
  assign last_beat = issue && (beats_left == `WRP_SIZE_W'(1));

  // beat payload, address widened to the memory address width
  always_comb begin
    beat.addr = `WRP_MEM_ADDR_W'(cur_addr);
    beat.data = outbuf_data[cur_pu];
  end

  assign beat_q.push      = issue;
  assign beat_q.push_data = beat;

  // pop the selected buffer in the same cycle the beat is pushed
  always_comb begin
    outbuf_pop = '0;
    if (issue) begin
      outbuf_pop[cur_pu] = 1'b1;
    end
  end

  assign busy = active;

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      active  <= 1'b0;
      wr_done <= 1'b0;
    end else begin
      wr_done <= last_beat;  // one cycle after the final push
      if (accept) begin
        active <= 1'b1;
      end else if (last_beat) begin
        active <= 1'b0;      // count hits zero, back to idle
      end
    end
  end

  // address, count and source of the active request
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_addr   <= next_req.addr;
      beats_left <= next_req.size;
      cur_pu     <= next_req.pu_id;
    end else if (issue) begin
      cur_addr   <= cur_addr + `WRP_ADDR_W'(`WRP_BEAT_BYTES);  // next 8-byte word
      beats_left <= beats_left - `WRP_SIZE_W'(1);
    end
  end

endmodule

// File: logic/sync_fifo.sv
// show-ahead synchronous FIFO, instantiated for the macro request and beat queues
module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  LOG_DEPTH = 2
) (
  input logic   clk,
  input logic   rst,
  queue_if.store q
);

  localparam int DEPTH = 1 << LOG_DEPTH;

  payload_t mem [DEPTH];  // entry storage

  logic [LOG_DEPTH-1:0] rd_ptr;  // head slot
  logic [LOG_DEPTH-1:0] wr_ptr;  // next free slot
  logic [LOG_DEPTH:0]   count;   // entries held, one extra bit for full

  logic do_push;
  logic do_pop;

  // status flags straight from the count
  assign q.full  = (count == (LOG_DEPTH + 1)'(DEPTH));
  assign q.empty = (count == '0);

  // strobes that actually take effect
  assign do_push = q.push && !q.full;
  assign do_pop  = q.pop && !q.empty;

  // head is visible without a pop
  assign q.pop_data = mem[rd_ptr];

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage write
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= q.push_data;
    end
  end

endmodule

// File: logic/queue_if.sv
// push and pop sides of one queue, shared by the FIFO and the blocks around it
interface queue_if #(
  parameter type payload_t = logic
);

  // push side
  logic     push;       // write strobe, dropped while full
  payload_t push_data;
  logic     full;

  // pop side
  logic     pop;        // read strobe, dropped while empty
  payload_t pop_data;   // head entry, valid while not empty
  logic     empty;

  // block writing into the queue
  modport producer (
    output push,
    output push_data,
    input  full
  );

  // block draining the queue
  modport consumer (
    output pop,
    input  pop_data,
    input  empty
  );

  // the queue storage itself
  modport store (
    input  push,
    input  push_data,
    input  pop,
    output full,
    output pop_data,
    output empty
  );

endinterface

// File: logic/wr_path_pkg.sv
// request and beat types shared by the write path RTL and its testbench
`include "wr_path_consts.svh"

package wr_path_pkg;

  // pu index width, one bit minimum even for a single PU
  localparam int PU_ID_W = ($clog2(`WRP_NUM_PU) > 0) ? $clog2(`WRP_NUM_PU) : 1;

  typedef logic [PU_ID_W-1:0] pu_id_t;

  // macro write request as queued from the controller
  typedef struct packed {
    logic [`WRP_ADDR_W-1:0] addr;  // start byte address
    logic [`WRP_SIZE_W-1:0] size;  // length in beats
    pu_id_t                 pu_id; // source output buffer
  } macro_req_t;

  // single-beat memory write
  typedef struct packed {
    logic [`WRP_MEM_ADDR_W-1:0] addr;  // zero-extended beat address
    logic [`WRP_DATA_W-1:0]     data;  // word popped from the PU buffer
  } beat_t;

endpackage

// File: logic/wr_path_consts.svh
// sizing macros for the write path, included by the RTL and the testbench
`ifndef WR_PATH_CONSTS_SVH
`define WR_PATH_CONSTS_SVH

// processing units feeding the write path
`define WRP_NUM_PU 2

// datapath widths
`define WRP_DATA_W 64      // one beat of output-buffer data
`define WRP_ADDR_W 32      // byte address of a macro request
`define WRP_MEM_ADDR_W 64  // memory request address, upper bits zero
`define WRP_SIZE_W 10      // beat count of a macro request

// bytes covered by one beat, address step per beat
`define WRP_BEAT_BYTES 8

// queue depths as log2
`define WRP_MACRO_Q_LOG_DEPTH 2  // 4 pending macro requests
`define WRP_BEAT_Q_LOG_DEPTH 3   // 8 beats waiting for grant

`endif
